/* src/llm_int_pkg.sv */
package llm_int_pkg;

    // Vectors hold VEC_LEN elements and matrices are VEC_LEN by VEC_LEN.
    localparam int VEC_LEN = 4;

    // At most this many outliers per vector take the full-precision path.
    localparam int HIGH_SLOTS = 2;

    // Shift amounts for quantizing inputs and for rescaling the two row sums.
    localparam int QUANT_SHIFT = 24;
    localparam int HIGH_SHIFT = 16;
    localparam int LOW_SHIFT = 8;

    typedef logic signed [31:0] elem_t;
    typedef logic signed [7:0] q_elem_t;

    // Row sums are wide enough to hold four full products exactly.
    typedef logic signed [65:0] hi_acc_t;
    typedef logic signed [17:0] lo_acc_t;

    // An element is an outlier when its magnitude is strictly above this.
    localparam elem_t OUTLIER_THRESHOLD = elem_t'(1 << 24);

    typedef elem_t [VEC_LEN-1:0] hi_vec_t;
    typedef q_elem_t [VEC_LEN-1:0] lo_vec_t;

    // Row r of a matrix produces output element r.
    typedef elem_t [VEC_LEN-1:0][VEC_LEN-1:0] hi_mat_t;
    typedef q_elem_t [VEC_LEN-1:0][VEC_LEN-1:0] lo_mat_t;

    typedef hi_acc_t [VEC_LEN-1:0] hi_acc_vec_t;
    typedef lo_acc_t [VEC_LEN-1:0] lo_acc_vec_t;

    typedef struct packed {
        hi_vec_t high;
        lo_vec_t low;
    } split_t;

endpackage

/* src/scatter_threshold.sv */
`timescale 1ns/1ns

module scatter_threshold (
    input  llm_int_pkg::hi_vec_t data_in,
    output llm_int_pkg::split_t  split
);

    import llm_int_pkg::*;

    logic [VEC_LEN-1:0] is_outlier;
    logic [VEC_LEN-1:0] is_marked;

    // Magnitude test done as two signed compares, so the most negative
    // value needs no special handling.
    always_comb begin
        for (int i = 0; i < VEC_LEN; i++) begin
            is_outlier[i] = (data_in[i] > OUTLIER_THRESHOLD) ||
                            (data_in[i] < -OUTLIER_THRESHOLD);
        end
    end

    // Scan from index 0 upward and mark outliers until the high slots run out.
    always_comb begin
        int taken;
        taken = 0;
        is_marked = '0;
        for (int i = 0; i < VEC_LEN; i++) begin
            if (is_outlier[i] && (taken < HIGH_SLOTS)) begin
                is_marked[i] = 1'b1;
                taken = taken + 1;
            end
        end
    end

    // Marked elements travel at full precision. The rest are quantized by
    // an arithmetic shift and keep only their low 8 bits.
    always_comb begin
        elem_t shifted;
        split = '0;
        for (int i = 0; i < VEC_LEN; i++) begin
            shifted = data_in[i] >>> QUANT_SHIFT;
            if (is_marked[i]) begin
                split.high[i] = data_in[i];
            end else begin
                split.low[i] = q_elem_t'(shifted);
            end
        end
    end

endmodule

/* src/fixed_linear.sv */
`timescale 1ns/1ns

module fixed_linear #(
    parameter type elem_type   = llm_int_pkg::q_elem_t,
    parameter type weight_type = llm_int_pkg::q_elem_t,
    parameter type acc_type    = llm_int_pkg::lo_acc_t
) (
    input  logic clk,
    input  logic reset,

    input  elem_type [llm_int_pkg::VEC_LEN-1:0] data_in,
    input  logic data_in_valid,
    output logic data_in_ready,
    input  logic data_in_fire,

    input  weight_type [llm_int_pkg::VEC_LEN-1:0][llm_int_pkg::VEC_LEN-1:0] weight,
    input  logic weight_valid,
    output logic weight_ready,

    output acc_type [llm_int_pkg::VEC_LEN-1:0] data_out,
    output logic data_out_valid,
    input  logic data_out_ready
);

    import llm_int_pkg::*;

    weight_type [VEC_LEN-1:0][VEC_LEN-1:0] weight_reg;

    acc_type [VEC_LEN-1:0][VEC_LEN-1:0] prod;
    logic prod_valid;

    acc_type [VEC_LEN-1:0] row_sum;
    acc_type [VEC_LEN-1:0] sum;
    logic sum_valid;

    logic sum_free;
    logic prod_free;
    logic take;

    // Each stage may load when it is empty or its content moves on this cycle.
    assign sum_free  = !sum_valid || data_out_ready;
    assign prod_free = !prod_valid || sum_free;

    assign data_in_ready = prod_free;

    // The fire strobe is the joint handshake across both linears.
    assign take = data_in_valid && data_in_fire;

    // Weights only change while nothing is in flight.
    assign weight_ready = !prod_valid && !sum_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            weight_reg <= '0;
        end else if (weight_valid && weight_ready) begin
            weight_reg <= weight;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prod_valid <= 1'b0;
        end else if (prod_free) begin
            prod_valid <= take;
        end
    end

    // Stage 1 holds every element-by-weight product, sign extended to the
    // accumulator width so the multiply is exact.
    always_ff @(posedge clk) begin
        if (prod_free && take) begin
            for (int r = 0; r < VEC_LEN; r++) begin
                for (int c = 0; c < VEC_LEN; c++) begin
                    prod[r][c] <= acc_type'(data_in[c]) * acc_type'(weight_reg[r][c]);
                end
            end
        end
    end

    always_comb begin
        for (int r = 0; r < VEC_LEN; r++) begin
            row_sum[r] = '0;
            for (int c = 0; c < VEC_LEN; c++) begin
                row_sum[r] = row_sum[r] + prod[r][c];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sum_valid <= 1'b0;
        end else if (sum_free) begin
            sum_valid <= prod_valid;
        end
    end

    // Stage 2 holds the row sums until the consumer takes them.
    always_ff @(posedge clk) begin
        if (sum_free && prod_valid) begin
            sum <= row_sum;
        end
    end

    assign data_out       = sum;
    assign data_out_valid = sum_valid;

endmodule

/* src/gather.sv */
`timescale 1ns/1ns

module gather (
    input  logic clk,
    input  logic reset,

    input  llm_int_pkg::hi_acc_vec_t high_sum,
    input  logic high_valid,
    output logic high_ready,

    input  llm_int_pkg::lo_acc_vec_t low_sum,
    input  logic low_valid,
    output logic low_ready,

    input  logic high_in_ready,
    input  logic low_in_ready,
    input  logic data_in_valid,
    output logic in_fire,
    output logic data_in_ready,

    output llm_int_pkg::hi_vec_t data_out,
    output logic data_out_valid,
    input  logic data_out_ready
);

    import llm_int_pkg::*;

    hi_vec_t combined;
    logic out_free;
    logic take;

    // The input vector is accepted only when both linears can take it.
    assign data_in_ready = high_in_ready && low_in_ready;
    assign in_fire       = data_in_valid && data_in_ready;

    assign out_free = !data_out_valid || data_out_ready;
    assign take     = high_valid && low_valid && out_free;

    // Each side is released only together with the other, so the two
    // pipelines stay in step.
    assign high_ready = low_valid && out_free;
    assign low_ready  = high_valid && out_free;

    always_comb begin
        elem_t high_part;
        elem_t low_part;
        for (int r = 0; r < VEC_LEN; r++) begin
            high_part   = elem_t'(high_sum[r] >>> HIGH_SHIFT);
            low_part    = elem_t'(low_sum[r]) <<< LOW_SHIFT;
            combined[r] = high_part + low_part;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            data_out_valid <= 1'b0;
        end else if (out_free) begin
            data_out_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            data_out <= combined;
        end
    end

endmodule

/* src/llm_int_linear.sv */
`timescale 1ns/1ns

module llm_int_linear (
    input  logic clk,
    input  logic reset,

    input  llm_int_pkg::hi_vec_t data_in,
    input  logic data_in_valid,
    output logic data_in_ready,

    input  llm_int_pkg::hi_mat_t weights,
    input  logic weight_valid,
    output logic weight_ready,

    input  llm_int_pkg::lo_mat_t q_weights,
    input  logic q_weight_valid,
    output logic q_weight_ready,

    output llm_int_pkg::hi_vec_t data_out,
    output logic data_out_valid,
    input  logic data_out_ready
);

    import llm_int_pkg::*;

    split_t split;

    hi_acc_vec_t high_sum;
    lo_acc_vec_t low_sum;
    logic high_valid;
    logic low_valid;
    logic high_ready;
    logic low_ready;

    logic high_in_ready;
    logic low_in_ready;
    logic in_fire;

    scatter_threshold scatter (
        .data_in (data_in),
        .split   (split)
    );

    // Full-precision path for the outliers.
    fixed_linear #(
        .elem_type   (elem_t),
        .weight_type (elem_t),
        .acc_type    (hi_acc_t)
    ) high_linear (
        .clk            (clk),
        .reset          (reset),
        .data_in        (split.high),
        .data_in_valid  (data_in_valid),
        .data_in_ready  (high_in_ready),
        .data_in_fire   (in_fire),
        .weight         (weights),
        .weight_valid   (weight_valid),
        .weight_ready   (weight_ready),
        .data_out       (high_sum),
        .data_out_valid (high_valid),
        .data_out_ready (high_ready)
    );

    // 8-bit path for the quantized remainder.
    fixed_linear #(
        .elem_type   (q_elem_t),
        .weight_type (q_elem_t),
        .acc_type    (lo_acc_t)
    ) low_linear (
        .clk            (clk),
        .reset          (reset),
        .data_in        (split.low),
        .data_in_valid  (data_in_valid),
        .data_in_ready  (low_in_ready),
        .data_in_fire   (in_fire),
        .weight         (q_weights),
        .weight_valid   (q_weight_valid),
        .weight_ready   (q_weight_ready),
        .data_out       (low_sum),
        .data_out_valid (low_valid),
        .data_out_ready (low_ready)
    );

    gather gather_out (
        .clk            (clk),
        .reset          (reset),
        .high_sum       (high_sum),
        .high_valid     (high_valid),
        .high_ready     (high_ready),
        .low_sum        (low_sum),
        .low_valid      (low_valid),
        .low_ready      (low_ready),
        .high_in_ready  (high_in_ready),
        .low_in_ready   (low_in_ready),
        .data_in_valid  (data_in_valid),
        .in_fire        (in_fire),
        .data_in_ready  (data_in_ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready)
    );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk
);

    // Free-running clock with a 10 ns period.
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

endmodule

/* verification/llm_int_linear_checker.sv */
`timescale 1ns/1ns

module llm_int_linear_checker (
    input logic clk,
    input logic reset,
    input logic data_in_valid,
    input logic data_in_ready,
    input logic weight_ready,
    input logic q_weight_ready,
    input logic high_valid,
    input logic low_valid,
    input llm_int_pkg::hi_vec_t data_out,
    input logic data_out_valid,
    input logic data_out_ready
);

    // A stalled output beat stays valid and unchanged until it is taken.
    out_hold: assert property (@(posedge clk) disable iff (reset)
        data_out_valid && !data_out_ready |=> data_out_valid && $stable(data_out))
        else $error("output beat changed or dropped while stalled");

    out_reset: assert property (@(posedge clk) reset |=> !data_out_valid)
        else $error("data_out_valid high after a reset cycle");

    // Neither weight register may load while a product is in flight.
    load_after_accept: assert property (@(posedge clk) disable iff (reset)
        data_in_valid && data_in_ready |=> !weight_ready && !q_weight_ready)
        else $error("weight_ready high right after an input transfer");

    // The two paths move in step, so a row sum pending on one side means
    // the other side is busy as well.
    load_while_busy: assert property (@(posedge clk) disable iff (reset)
        !(high_valid && q_weight_ready) && !(low_valid && weight_ready))
        else $error("weight_ready high while the other path holds a row sum");

endmodule

bind llm_int_linear llm_int_linear_checker i_checker (.*);

/* verification/tb_llm_int_linear.sv */
`timescale 1ns/1ns

module tb_llm_int_linear;

    import llm_int_pkg::*;

    localparam int STIM_ROWS = 15;
    localparam int TIMEOUT = 40 * STIM_ROWS + 100;
    localparam int SEED = 32'h4810_0f43;

    // Weight set to load first (0 keeps the current one), random back-pressure,
    // random vector instead of the listed one, and the listed vector.
    typedef struct packed {
        logic [1:0] wsel;
        logic bp;
        logic rnd;
        hi_vec_t vec;
    } stim_t;

    typedef struct packed {
        hi_vec_t vec;
        int cycle;
        logic timed;
    } exp_t;

    logic clk;
    logic reset;
    hi_vec_t data_in;
    logic data_in_valid;
    logic data_in_ready;
    hi_mat_t weights;
    logic weight_valid;
    logic weight_ready;
    lo_mat_t q_weights;
    logic q_weight_valid;
    logic q_weight_ready;
    hi_vec_t data_out;
    logic data_out_valid;
    logic data_out_ready;

    hi_mat_t w_sets [3];
    lo_mat_t qw_sets [3];
    hi_mat_t cur_w;
    lo_mat_t cur_qw;
    logic cur_bp;
    int cycle;
    exp_t exp_q [$];

    stim_t stim_table [STIM_ROWS] = '{
        '{2'd0, 1'b0, 1'b0, {32'h0200_0000, 32'h0000_1000, 32'hFE00_0000, 32'h0050_0000}},
        '{2'd1, 1'b0, 1'b0, {32'h00F0_0000, 32'hFFFF_FC18, 32'h0100_0000, 32'h0012_3456}},
        '{2'd0, 1'b0, 1'b0, {32'h0000_0010, 32'h7FFF_FFFF, 32'h00A0_0000, 32'hFF80_0000}},
        '{2'd0, 1'b0, 1'b0, {32'h8000_0000, 32'h0000_1234, 32'h0200_0001, 32'h0010_0000}},
        '{2'd0, 1'b0, 1'b0, {32'h0300_0000, 32'hF000_0000, 32'h0000_0005, 32'h0500_0000}},
        '{2'd0, 1'b0, 1'b0, {32'h4000_0000, 32'hC000_0000, 32'h0FFF_FFFF, 32'hF100_0000}},
        '{2'd0, 1'b0, 1'b0, {32'hFF00_0000, 32'h0100_0001, 32'h0000_0000, 32'h0000_0000}},
        '{2'd0, 1'b1, 1'b1, '0},
        '{2'd0, 1'b1, 1'b1, '0},
        '{2'd0, 1'b1, 1'b1, '0},
        '{2'd0, 1'b1, 1'b1, '0},
        '{2'd2, 1'b1, 1'b1, '0},
        '{2'd0, 1'b1, 1'b1, '0},
        '{2'd0, 1'b1, 1'b1, '0},
        '{2'd0, 1'b1, 1'b1, '0}
    };

    tb_clock_gen i_clk (.clk(clk));

    llm_int_linear i_dut (.*);

    task automatic stop_with_failure(string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_vec(string name, hi_vec_t got, hi_vec_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERR %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERR %s got %h expected %h", name, got, exp));
        end
    endtask

    // Up to two outliers by index keep full precision, the rest are quantized,
    // and the two row sums are rescaled and added with 32-bit wrap.
    function automatic hi_vec_t model_output(hi_vec_t v, hi_mat_t w, lo_mat_t qw);
        hi_vec_t res;
        hi_acc_t hs;
        int ls;
        int taken;
        longint mag;
        logic [VEC_LEN-1:0] high;
        taken = 0;
        for (int c = 0; c < VEC_LEN; c++) begin
            mag = longint'(v[c]);
            if (mag < 0) begin
                mag = -mag;
            end
            high[c] = (mag > longint'(OUTLIER_THRESHOLD)) && (taken < HIGH_SLOTS);
            if (high[c]) begin
                taken = taken + 1;
            end
        end
        for (int r = 0; r < VEC_LEN; r++) begin
            hs = '0;
            ls = 0;
            for (int c = 0; c < VEC_LEN; c++) begin
                if (high[c]) begin
                    hs = hs + hi_acc_t'(v[c]) * hi_acc_t'(w[r][c]);
                end else begin
                    ls = ls + int'(q_elem_t'(v[c] >>> QUANT_SHIFT)) * int'(qw[r][c]);
                end
            end
            res[r] = elem_t'(hs >>> HIGH_SHIFT) + elem_t'(ls << LOW_SHIFT);
        end
        return res;
    endfunction

    function automatic hi_vec_t random_vec();
        hi_vec_t v;
        for (int i = 0; i < VEC_LEN; i++) begin
            v[i] = elem_t'($signed($urandom) >>> ($urandom % 9));
        end
        return v;
    endfunction

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic load_weights(hi_mat_t w, lo_mat_t qw);
        weights = w;
        q_weights = qw;
        weight_valid = 1'b1;
        q_weight_valid = 1'b1;
        @(posedge clk);
        check_flag("weight_ready", weight_ready, 1'b1);
        check_flag("q_weight_ready", q_weight_ready, 1'b1);
        cur_w = w;
        cur_qw = qw;
        #1;
        weight_valid = 1'b0;
        q_weight_valid = 1'b0;
    endtask

    task automatic send_vec(hi_vec_t v);
        exp_t e;
        data_in = v;
        data_in_valid = 1'b1;
        @(posedge clk);
        // Without back-pressure the pipeline must accept a vector every cycle.
        if (!cur_bp) begin
            check_flag("data_in_ready", data_in_ready, 1'b1);
        end
        while (!data_in_ready) begin
            @(posedge clk);
        end
        e.vec = model_output(v, cur_w, cur_qw);
        e.cycle = cycle;
        e.timed = !cur_bp;
        exp_q.push_back(e);
        #1;
        data_in_valid = 1'b0;
    endtask

    task automatic apply_row(stim_t row);
        if (row.wsel != 2'd0 || row.bp != cur_bp) begin
            wait_drain();
        end
        cur_bp = row.bp;
        if (row.wsel != 2'd0) begin
            load_weights(w_sets[row.wsel], qw_sets[row.wsel]);
        end
        send_vec(row.rnd ? random_vec() : row.vec);
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) begin
            stop_with_failure($sformatf("run did not finish within %0d cycles", TIMEOUT));
        end
    end

    always @(posedge clk) begin
        #1;
        data_out_ready = cur_bp ? 1'($urandom % 2) : 1'b1;
    end

    always @(posedge clk) begin
        exp_t e;
        if (!reset && data_out_valid && data_out_ready) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("DUT sent an output beat with no vector accepted for it");
            end else begin
                e = exp_q.pop_front();
                check_vec("data_out", data_out, e.vec);
                if (e.timed && (cycle - e.cycle != 3)) begin
                    stop_with_failure($sformatf("output came %0d cycles after acceptance, not 3",
                                                cycle - e.cycle));
                end
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        reset = 1'b1;
        data_in = '0;
        data_in_valid = 1'b0;
        weights = '0;
        weight_valid = 1'b0;
        q_weights = '0;
        q_weight_valid = 1'b0;
        data_out_ready = 1'b1;
        cur_bp = 1'b0;
        cur_w = '0;
        cur_qw = '0;
        for (int s = 0; s < 3; s++) begin
            for (int r = 0; r < VEC_LEN; r++) begin
                for (int c = 0; c < VEC_LEN; c++) begin
                    w_sets[s][r][c] = elem_t'($urandom);
                    qw_sets[s][r][c] = q_elem_t'($urandom);
                end
            end
        end
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        check_flag("data_out_valid", data_out_valid, 1'b0);
        check_flag("data_in_ready", data_in_ready, 1'b1);
        check_flag("weight_ready", weight_ready, 1'b1);
        check_flag("q_weight_ready", q_weight_ready, 1'b1);
        for (int i = 0; i < STIM_ROWS; i++) begin
            apply_row(stim_table[i]);
        end
        wait_drain();
        // A few idle cycles let a duplicated beat show up in the monitor.
        repeat (5) @(posedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* tb.f */
src/llm_int_pkg.sv
src/scatter_threshold.sv
src/fixed_linear.sv
src/gather.sv
src/llm_int_linear.sv
verification/tb_clock_gen.sv
verification/llm_int_linear_checker.sv
verification/tb_llm_int_linear.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_llm_int_linear -o sim_tb

output=$(./obj_dir/sim_tb || true)
echo "$output"

if echo "$output" | grep -q "TEST PASSED"; then
    exit 0
else
    exit 1
fi
